// File: design/reset_config.svh
// sizing and power-on values shared by the reset sequencer, included by the package and RTL
`ifndef RESET_CONFIG_SVH
`define RESET_CONFIG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// register port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define CFG_ADDR_W 2
`define CFG_DATA_W 16

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// power-on register values
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define MED_DIV_RESET 63
`define SLOW_DIV_RESET 4095
`define BOOT_LEN_RESET 1

// slow-tick samples the button must stay high
`define DEBOUNCE_LEN 10

`endif

// File: design/reset_pkg.sv
// types shared by the reset sequencer blocks, imported by each module that needs them
`default_nettype none

`include "reset_config.svh"

package reset_pkg;

   // register port
   typedef logic [`CFG_ADDR_W-1:0] cfg_addr_t;
   typedef logic [`CFG_DATA_W-1:0] cfg_data_t;

   // tick fires every divisor plus one cycles
   typedef logic [15:0] tick_div_t;
   // boot strobe length in medium ticks
   typedef logic [3:0] boot_len_t;
   typedef logic [`DEBOUNCE_LEN-1:0] press_hist_t;

   // board level sequence
   typedef enum logic [2:0] {
      p_init,
      p_reset1,
      p_reset2,
      p_reset3,
      p_start,
      p_wait,
      p_idle
   } pwr_state_e;

   // processor sequence
   typedef enum logic [2:0] {
      c_init,
      c_reset1,
      c_reset2,
      c_reset3,
      c_boot,
      c_wait,
      c_idle
   } cpu_state_e;

endpackage

`default_nettype wire

// File: design/seq_cfg_if.sv
// configuration path from the register block to the tick, filter and cpu sequencing logic
`default_nettype none

interface seq_cfg_if import reset_pkg::*; ();

   tick_div_t med_div;
   tick_div_t slow_div;
   boot_len_t boot_len;
   // one cycle after a write to the restart address
   logic soft_press;

   modport regs (
      output med_div,
      output slow_div,
      output boot_len,
      output soft_press
   );

   modport ticks (
      input med_div,
      input slow_div
   );

   modport cpu (
      input boot_len
   );

   modport press (
      input soft_press
   );

endinterface

`default_nettype wire

// File: design/seq_regs.sv
// configuration registers on a four-phase req/ack port, driving the sequencer settings
`default_nettype none

`include "reset_config.svh"

module seq_regs import reset_pkg::*; (
   input  wire       sysclk,
   input  wire       dcm_reset,
   input  wire       cfg_req,
   input  wire       cfg_we,
   input  wire       cfg_addr_t cfg_addr,
   input  wire       cfg_data_t cfg_wdata,
   output logic      cfg_ack,
   output cfg_data_t cfg_rdata,
   seq_cfg_if.regs   cfg
);

   localparam cfg_addr_t ADDR_MED_DIV  = 2'd0;
   localparam cfg_addr_t ADDR_SLOW_DIV = 2'd1;
   localparam cfg_addr_t ADDR_BOOT_LEN = 2'd2;
   localparam cfg_addr_t ADDR_RESTART  = 2'd3;

   logic      access;
   cfg_data_t rd_mux;

   // a new request is accepted only once the previous ack has dropped
   assign access = cfg_req && !cfg_ack;

   always_comb begin
      case (cfg_addr)
         ADDR_MED_DIV:  rd_mux = cfg_data_t'(cfg.med_div);
         ADDR_SLOW_DIV: rd_mux = cfg_data_t'(cfg.slow_div);
         ADDR_BOOT_LEN: rd_mux = cfg_data_t'(cfg.boot_len);
         default:       rd_mux = '0;
      endcase
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // handshake
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge sysclk or posedge dcm_reset) begin
      if (dcm_reset) begin
         cfg_ack <= 1'b0;
      end else if (access) begin
         cfg_ack <= 1'b1;
      end else if (!cfg_req) begin
         cfg_ack <= 1'b0;
      end
   end

   // read data held until the next access
   always_ff @(posedge sysclk) begin
      if (access) begin
         cfg_rdata <= rd_mux;
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // register file
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge sysclk or posedge dcm_reset) begin
      if (dcm_reset) begin
         cfg.med_div    <= tick_div_t'(`MED_DIV_RESET);
         cfg.slow_div   <= tick_div_t'(`SLOW_DIV_RESET);
         cfg.boot_len   <= boot_len_t'(`BOOT_LEN_RESET);
         cfg.soft_press <= 1'b0;
      end else begin
         cfg.soft_press <= access && cfg_we && (cfg_addr == ADDR_RESTART);
         if (access && cfg_we) begin
            case (cfg_addr)
               ADDR_MED_DIV:  cfg.med_div  <= tick_div_t'(cfg_wdata);
               ADDR_SLOW_DIV: cfg.slow_div <= tick_div_t'(cfg_wdata);
               ADDR_BOOT_LEN: cfg.boot_len <= cfg_wdata[3:0];
               default: ;
            endcase
         end
      end
   end

endmodule

`default_nettype wire

// File: design/tick_gen.sv
// programmable dividers giving the medium and slow sequencing ticks from sysclk
`default_nettype none

module tick_gen import reset_pkg::*; (
   input  wire     sysclk,
   input  wire     dcm_reset,
   seq_cfg_if.ticks cfg,
   output logic    med_tick,
   output logic    slow_tick
);

   // index 0 is the medium tick, 1 the slow tick
   tick_div_t  div [2];
   tick_div_t  cnt [2];
   logic [1:0] tick;

   assign div[0] = cfg.med_div;
   assign div[1] = cfg.slow_div;

   // down-counters, the divisor is only picked up on reload
   always_ff @(posedge sysclk or posedge dcm_reset) begin
      if (dcm_reset) begin
         for (int i = 0; i < 2; i++) begin
            cnt[i] <= '0;
         end
         tick <= '0;
      end else begin
         for (int i = 0; i < 2; i++) begin
            if (cnt[i] == '0) begin
               cnt[i]  <= div[i];
               tick[i] <= 1'b1;
            end else begin
               cnt[i]  <= cnt[i] - 1'b1;
               tick[i] <= 1'b0;
            end
         end
      end
   end

   assign med_tick  = tick[0];
   assign slow_tick = tick[1];

endmodule

`default_nettype wire

// File: design/press_filter.sv
// reset button debouncer on the slow tick, merged with the software restart request
`default_nettype none

`include "reset_config.svh"

module press_filter import reset_pkg::*; (
   input  wire      sysclk,
   input  wire      dcm_reset,
   input  wire      slow_tick,
   input  wire      button_r,
   seq_cfg_if.press cfg,
   output logic     press,
   output logic     held
);

   press_hist_t hist;
   press_hist_t hist_next;

   assign hist_next = {hist[`DEBOUNCE_LEN-2:0], button_r};

   always_ff @(posedge sysclk or posedge dcm_reset) begin
      if (dcm_reset) begin
         hist <= '0;
      end else if (slow_tick) begin
         hist <= hist_next;
      end
   end

   // level stays high as long as every sample in the window was high
   assign held = &hist;

   // pulse on the sample that first completes the window
   always_ff @(posedge sysclk or posedge dcm_reset) begin
      if (dcm_reset) begin
         press <= 1'b0;
      end else begin
         press <= (slow_tick && (&hist_next) && !held) || cfg.soft_press;
      end
   end

endmodule

`default_nettype wire

// File: design/power_sequencer.sv
// board reset FSM: memory reset pulse, calibration wait, processor start and restart on press
`default_nettype none

module power_sequencer import reset_pkg::*; (
   input  wire  sysclk,
   input  wire  dcm_reset,
   input  wire  med_tick,
   input  wire  press,
   input  wire  held,
   input  wire  calib_done,
   input  wire  cpu_idle,
   output logic cpu_start,
   output logic pwr_settled,
   output logic pwr_in_reset,
   output logic lpddr_reset
);

   pwr_state_e state;
   pwr_state_e state_next;
   logic       press_pend;

   // press is one cycle wide, keep it until the FSM steps
   always_ff @(posedge sysclk or posedge dcm_reset) begin
      if (dcm_reset) begin
         press_pend <= 1'b0;
      end else if (med_tick) begin
         press_pend <= 1'b0;
      end else if (press && state == p_idle) begin
         press_pend <= 1'b1;
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // state machine
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_comb begin
      state_next = state;
      case (state)
         p_init:   state_next = p_reset1;
         p_reset1: state_next = p_reset2;
         p_reset2: state_next = p_reset3;
         p_reset3: if (calib_done) state_next = p_start;
         // processor has left idle, so it picked up the start
         p_start:  if (!cpu_idle) state_next = p_wait;
         // hold off until the button is let go
         p_wait:   if (!held) state_next = p_idle;
         p_idle:   if (press_pend || press) state_next = p_reset1;
         default:  state_next = p_init;
      endcase
   end

   always_ff @(posedge sysclk or posedge dcm_reset) begin
      if (dcm_reset) begin
         state <= p_init;
      end else if (med_tick) begin
         state <= state_next;
      end
   end

   assign cpu_start    = (state == p_start);
   assign pwr_settled  = (state == p_idle);
   assign lpddr_reset  = (state == p_reset1);
   assign pwr_in_reset = (state == p_init) || (state == p_reset1) ||
                         (state == p_reset2) || (state == p_reset3);

endmodule

`default_nettype wire

// File: design/cpu_sequencer.sv
// processor reset FSM: reset hold, programmable boot strobe, then run once power has settled
`default_nettype none

module cpu_sequencer import reset_pkg::*; (
   input  wire    sysclk,
   input  wire    dcm_reset,
   input  wire    med_tick,
   input  wire    cpu_start,
   input  wire    pwr_settled,
   input  wire    pwr_in_reset,
   seq_cfg_if.cpu cfg,
   output logic   cpu_idle,
   output logic   cpu_reset,
   output logic   boot
);

   cpu_state_e state;
   boot_len_t  boot_cnt;
   logic       cpu_in_reset;

   always_ff @(posedge sysclk or posedge dcm_reset) begin
      if (dcm_reset) begin
         state    <= c_init;
         boot_cnt <= '0;
      end else if (med_tick) begin
         case (state)
            c_init, c_idle: if (cpu_start) state <= c_reset1;
            c_reset1: state <= c_reset2;
            c_reset2: state <= c_reset3;
            // c_reset3 already drives boot, so a zero length skips c_boot
            c_reset3: begin
               if (cfg.boot_len == '0) begin
                  state <= c_wait;
               end else begin
                  state    <= c_boot;
                  boot_cnt <= cfg.boot_len - 1'b1;
               end
            end
            c_boot: begin
               if (boot_cnt == '0) begin
                  state <= c_wait;
               end else begin
                  boot_cnt <= boot_cnt - 1'b1;
               end
            end
            c_wait: if (pwr_settled) state <= c_idle;
            default: state <= c_init;
         endcase
      end
   end

   assign cpu_in_reset = (state == c_init) || (state == c_reset1) ||
                         (state == c_reset2) || (state == c_reset3);

   // board reset also holds the processor
   assign cpu_reset = cpu_in_reset || pwr_in_reset;
   assign boot      = (state == c_reset3) || (state == c_boot);
   assign cpu_idle  = (state == c_idle);

endmodule

`default_nettype wire

// File: design/reset_ctrl_top.sv
// top of the reset and boot sequencer, connecting registers, ticks, button filter and FSMs
`default_nettype none

module reset_ctrl_top import reset_pkg::*; (
   input  wire       sysclk,
   input  wire       dcm_reset,
   input  wire       button_r,
   input  wire       calib_done,
   input  wire       cfg_req,
   input  wire       cfg_we,
   input  wire       cfg_addr_t cfg_addr,
   input  wire       cfg_data_t cfg_wdata,
   output logic      cfg_ack,
   output cfg_data_t cfg_rdata,
   output logic      cpu_reset,
   output logic      boot,
   output logic      lpddr_reset
);

   logic med_tick;
   logic slow_tick;
   logic press;
   logic held;
   logic cpu_start;
   logic pwr_settled;
   logic pwr_in_reset;
   logic cpu_idle;

   seq_cfg_if i_seq_cfg_if ();

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // configuration and timing
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   seq_regs i_seq_regs (
      .sysclk    (sysclk),
      .dcm_reset (dcm_reset),
      .cfg_req   (cfg_req),
      .cfg_we    (cfg_we),
      .cfg_addr  (cfg_addr),
      .cfg_wdata (cfg_wdata),
      .cfg_ack   (cfg_ack),
      .cfg_rdata (cfg_rdata),
      .cfg       (i_seq_cfg_if.regs)
   );

   tick_gen i_tick_gen (
      .sysclk    (sysclk),
      .dcm_reset (dcm_reset),
      .cfg       (i_seq_cfg_if.ticks),
      .med_tick  (med_tick),
      .slow_tick (slow_tick)
   );

   press_filter i_press_filter (
      .sysclk    (sysclk),
      .dcm_reset (dcm_reset),
      .slow_tick (slow_tick),
      .button_r  (button_r),
      .cfg       (i_seq_cfg_if.press),
      .press     (press),
      .held      (held)
   );

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // sequencers
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   power_sequencer i_power_sequencer (
      .sysclk       (sysclk),
      .dcm_reset    (dcm_reset),
      .med_tick     (med_tick),
      .press        (press),
      .held         (held),
      .calib_done   (calib_done),
      .cpu_idle     (cpu_idle),
      .cpu_start    (cpu_start),
      .pwr_settled  (pwr_settled),
      .pwr_in_reset (pwr_in_reset),
      .lpddr_reset  (lpddr_reset)
   );

   cpu_sequencer i_cpu_sequencer (
      .sysclk       (sysclk),
      .dcm_reset    (dcm_reset),
      .med_tick     (med_tick),
      .cpu_start    (cpu_start),
      .pwr_settled  (pwr_settled),
      .pwr_in_reset (pwr_in_reset),
      .cfg          (i_seq_cfg_if.cpu),
      .cpu_idle     (cpu_idle),
      .cpu_reset    (cpu_reset),
      .boot         (boot)
   );

endmodule

`default_nettype wire

// File: dv/reset_ctrl_checker.sv
// monitor that the testbench top places beside the DUT to check pulse widths and register reads
`default_nettype none

`include "reset_config.svh"

module reset_ctrl_checker import reset_pkg::*; (
   input  wire       sysclk,
   input  wire       dcm_reset,
   input  wire       calib_done,
   input  wire       cfg_req,
   input  wire       cfg_we,
   input  wire       cfg_addr_t cfg_addr,
   input  wire       cfg_data_t cfg_wdata,
   input  wire       cfg_ack,
   input  wire       cfg_data_t cfg_rdata,
   input  wire       cpu_reset,
   input  wire       boot,
   input  wire       lpddr_reset,
   output int        errors,
   output int        checks,
   output int        lpddr_pulses,
   output int        boot_pulses
);

   timeunit 1ns;
   timeprecision 100ps;

   int        err_cnt = 0;
   int        chk_cnt = 0;
   int        test_base = 0;
   int        lp_cnt = 0;
   int        bt_cnt = 0;
   int        boot_run;
   int        lpddr_run;
   logic      rst_seen = 1'b0;
   logic      calib_seen;
   logic      req_q;
   logic      ack_q;
   logic      boot_q;
   logic      lpddr_q;
   tick_div_t med_sh;
   tick_div_t slow_sh;
   boot_len_t blen_sh;

   assign errors       = err_cnt;
   assign checks       = chk_cnt;
   assign lpddr_pulses = lp_cnt;
   assign boot_pulses  = bt_cnt;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // reference model
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   function automatic int lpddr_width(input tick_div_t med);
      return int'(med) + 1;
   endfunction

   // boot covers c_reset3 plus boot_len ticks in c_boot
   function automatic int boot_width(input tick_div_t med, input boot_len_t blen);
      return (int'(blen) + 1) * (int'(med) + 1);
   endfunction

   function automatic cfg_data_t read_value(input cfg_addr_t addr, input tick_div_t med,
                                            input tick_div_t slow, input boot_len_t blen);
      case (addr)
         2'd0:    return cfg_data_t'(med);
         2'd1:    return cfg_data_t'(slow);
         2'd2:    return {12'h000, blen};
         default: return '0;
      endcase
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      chk_cnt++;
      if (got !== exp) begin
         err_cnt++;
         $display("FAILED %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic check_counts(input int lp, input int bt);
      check_value("lpddr_reset pulses", lp_cnt, lp);
      check_value("boot pulses", bt_cnt, bt);
   endtask

   task automatic end_test(input string name);
      if (err_cnt == test_base) begin
         $display("test %s: ok", name);
      end else begin
         $display("test %s: %0d errors", name, err_cnt - test_base);
      end
      test_base = err_cnt;
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // monitor
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always @(posedge sysclk) begin
      if (dcm_reset) begin
         // outputs are unknown before the first reset edge
         if (rst_seen) begin
            check_value("cpu_reset", cpu_reset, 1);
            check_value("boot", boot, 0);
            check_value("lpddr_reset", lpddr_reset, 0);
            check_value("cfg_ack", cfg_ack, 0);
         end
         rst_seen    = 1'b1;
         med_sh      = tick_div_t'(`MED_DIV_RESET);
         slow_sh     = tick_div_t'(`SLOW_DIV_RESET);
         blen_sh     = boot_len_t'(`BOOT_LEN_RESET);
         calib_seen  = 1'b0;
         req_q       = 1'b0;
         ack_q       = 1'b0;
         boot_q      = 1'b0;
         lpddr_q     = 1'b0;
         boot_run    = 0;
         lpddr_run   = 0;
      end else begin
         // ack follows req by one cycle in both directions
         check_value("cfg_ack", cfg_ack, req_q);
         if (cfg_ack && !ack_q && !cfg_we) begin
            check_value("cfg_rdata", cfg_rdata, read_value(cfg_addr, med_sh, slow_sh, blen_sh));
         end
         if (cfg_req && !cfg_ack && cfg_we) begin
            case (cfg_addr)
               2'd0:    med_sh = tick_div_t'(cfg_wdata);
               2'd1:    slow_sh = tick_div_t'(cfg_wdata);
               2'd2:    blen_sh = boot_len_t'(cfg_wdata[3:0]);
               default: ;
            endcase
         end

         // nothing may pass p_reset3 before calibration
         if (calib_done) begin
            calib_seen = 1'b1;
         end
         if (!calib_seen) begin
            check_value("cpu_reset", cpu_reset, 1);
            check_value("boot", boot, 0);
         end

         if (lpddr_q && !lpddr_reset) begin
            check_value("lpddr_reset width", lpddr_run, lpddr_width(med_sh));
            lp_cnt <= lp_cnt + 1;
         end
         if (boot_q && !boot) begin
            check_value("boot width", boot_run, boot_width(med_sh, blen_sh));
            bt_cnt <= bt_cnt + 1;
         end
         // processor leaves reset one tick into the boot strobe
         if (boot) begin
            check_value("cpu_reset during boot", cpu_reset, boot_run < lpddr_width(med_sh));
         end

         lpddr_run   = lpddr_reset ? lpddr_run + 1 : 0;
         boot_run    = boot ? boot_run + 1 : 0;
         req_q       = cfg_req;
         ack_q       = cfg_ack;
         boot_q      = boot;
         lpddr_q     = lpddr_reset;
      end
   end

endmodule

`default_nettype wire

// File: dv/reset_ctrl_tb.sv
// top testbench for the reset sequencer, drives clock, reset, registers and button through the tests
`default_nettype none

`include "reset_config.svh"

module reset_ctrl_tb import reset_pkg::*; ();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int SEQ_TIMEOUT = 20000;
   localparam int ACK_TIMEOUT = 8;

   logic      sysclk;
   logic      dcm_reset;
   logic      button_r;
   logic      calib_done;
   logic      cfg_req;
   logic      cfg_we;
   cfg_addr_t cfg_addr;
   cfg_data_t cfg_wdata;
   logic      cfg_ack;
   cfg_data_t cfg_rdata;
   logic      cpu_reset;
   logic      boot;
   logic      lpddr_reset;
   int        errors;
   int        checks;
   int        lpddr_pulses;
   int        boot_pulses;
   tick_div_t med_div;
   tick_div_t slow_div;
   boot_len_t boot_len;
   int        glitch_len;
   int        exp_lp;
   int        exp_bt;

   reset_ctrl_top i_reset_ctrl_top (
      .sysclk      (sysclk),
      .dcm_reset   (dcm_reset),
      .button_r    (button_r),
      .calib_done  (calib_done),
      .cfg_req     (cfg_req),
      .cfg_we      (cfg_we),
      .cfg_addr    (cfg_addr),
      .cfg_wdata   (cfg_wdata),
      .cfg_ack     (cfg_ack),
      .cfg_rdata   (cfg_rdata),
      .cpu_reset   (cpu_reset),
      .boot        (boot),
      .lpddr_reset (lpddr_reset)
   );

   reset_ctrl_checker i_reset_ctrl_checker (
      .sysclk       (sysclk),
      .dcm_reset    (dcm_reset),
      .calib_done   (calib_done),
      .cfg_req      (cfg_req),
      .cfg_we       (cfg_we),
      .cfg_addr     (cfg_addr),
      .cfg_wdata    (cfg_wdata),
      .cfg_ack      (cfg_ack),
      .cfg_rdata    (cfg_rdata),
      .cpu_reset    (cpu_reset),
      .boot         (boot),
      .lpddr_reset  (lpddr_reset),
      .errors       (errors),
      .checks       (checks),
      .lpddr_pulses (lpddr_pulses),
      .boot_pulses  (boot_pulses)
   );

   initial begin
      sysclk = 1'b0;
      forever #5 sysclk = ~sysclk;
   end

   task automatic abort_run(input string what);
      $display("timeout waiting for %s at %0t", what, $time);
      $display("RESULT: FAIL");
      $finish;
   endtask

   // one four-phase access, called right after a rising edge
   task automatic cfg_access(input logic we, input cfg_addr_t addr, input cfg_data_t data);
      int n;
      cfg_req   <= 1'b1;
      cfg_we    <= we;
      cfg_addr  <= addr;
      cfg_wdata <= data;
      n = 0;
      do begin
         @(posedge sysclk);
         n++;
      end while (!cfg_ack && n < ACK_TIMEOUT);
      if (!cfg_ack) begin
         abort_run("cfg_ack to rise");
      end
      cfg_req <= 1'b0;
      n = 0;
      do begin
         @(posedge sysclk);
         n++;
      end while (cfg_ack && n < ACK_TIMEOUT);
      if (cfg_ack) begin
         abort_run("cfg_ack to fall");
      end
   endtask

   task automatic wait_pulses(input int lp, input int bt, input string what);
      int n;
      n = 0;
      while ((lpddr_pulses < lp || boot_pulses < bt) && n < SEQ_TIMEOUT) begin
         @(posedge sysclk);
         n++;
      end
      if (lpddr_pulses < lp || boot_pulses < bt) begin
         abort_run(what);
      end
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // test sequence
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   initial begin
      void'($urandom(32'hf318));
      dcm_reset  = 1'b1;
      button_r   = 1'b0;
      calib_done = 1'b0;
      cfg_req    = 1'b0;
      cfg_we     = 1'b0;
      cfg_addr   = '0;
      cfg_wdata  = '0;
      exp_lp = 0;
      exp_bt = 0;
      repeat (16) @(posedge sysclk);
      dcm_reset <= 1'b0;

      // power-up stops at p_reset3 without calibration
      exp_lp = 1;
      wait_pulses(exp_lp, exp_bt, "first lpddr_reset pulse");
      repeat (40 * (`MED_DIV_RESET + 1)) @(posedge sysclk);
      i_reset_ctrl_checker.check_counts(exp_lp, exp_bt);
      i_reset_ctrl_checker.end_test("power-up hold");

      med_div  = tick_div_t'(4 + $urandom % 16);
      slow_div = tick_div_t'(6 + $urandom % 16);
      boot_len = boot_len_t'($urandom % 8);
      cfg_access(1'b1, 2'd0, cfg_data_t'(med_div));
      cfg_access(1'b1, 2'd1, cfg_data_t'(slow_div));
      cfg_access(1'b1, 2'd2, cfg_data_t'(boot_len));
      for (int a = 0; a < 4; a++) begin
         cfg_access(1'b0, cfg_addr_t'(a), '0);
      end
      i_reset_ctrl_checker.end_test("register access");

      calib_done <= 1'b1;
      exp_bt = 1;
      wait_pulses(exp_lp, exp_bt, "boot strobe after calibration");
      i_reset_ctrl_checker.check_counts(exp_lp, exp_bt);
      i_reset_ctrl_checker.end_test("boot after calibration");

      // the old slow divisor may still be counting down
      repeat (`SLOW_DIV_RESET + 1) @(posedge sysclk);
      glitch_len = 1 + $urandom % (`DEBOUNCE_LEN - 3);
      button_r <= 1'b1;
      repeat (glitch_len * (int'(slow_div) + 1)) @(posedge sysclk);
      button_r <= 1'b0;
      repeat ((`DEBOUNCE_LEN + 2) * (int'(slow_div) + 1)) @(posedge sysclk);
      i_reset_ctrl_checker.check_counts(exp_lp, exp_bt);
      button_r <= 1'b1;
      exp_lp++;
      wait_pulses(exp_lp, exp_bt, "lpddr_reset after button press");
      button_r <= 1'b0;
      exp_bt++;
      wait_pulses(exp_lp, exp_bt, "boot strobe after button press");
      i_reset_ctrl_checker.check_counts(exp_lp, exp_bt);
      i_reset_ctrl_checker.end_test("button restart");

      exp_lp++;
      exp_bt++;
      cfg_access(1'b1, 2'd3, 16'h0001);
      wait_pulses(exp_lp, exp_bt, "sequence after soft restart");
      i_reset_ctrl_checker.check_counts(exp_lp, exp_bt);
      i_reset_ctrl_checker.end_test("soft restart");

      $display("tests 5, checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: sim.f
+incdir+design
design/reset_pkg.sv
design/seq_cfg_if.sv
design/seq_regs.sv
design/tick_gen.sv
design/press_filter.sv
design/power_sequencer.sv
design/cpu_sequencer.sv
design/reset_ctrl_top.sv
dv/reset_ctrl_checker.sv
dv/reset_ctrl_tb.sv

// File: Bender.yml
package:
  name: reset_ctrl

sources:
  - include_dirs:
      - design
    files:
      - design/reset_pkg.sv
      - design/seq_cfg_if.sv
      - design/seq_regs.sv
      - design/tick_gen.sv
      - design/press_filter.sv
      - design/power_sequencer.sv
      - design/cpu_sequencer.sv
      - design/reset_ctrl_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - dv/reset_ctrl_checker.sv
      - dv/reset_ctrl_tb.sv
